// File: src/vj_pkg.sv
// face detector constants and cascade tables
`default_nettype none

package vj_pkg;

  // image geometry
  localparam int img_w    = 12;
  localparam int img_h    = 12;
  localparam int win_size = 6;

  localparam int pixel_w = 8;
  localparam int sum_w   = 16;  // 144 * 255 fits
  localparam int acc_w   = 24;
  localparam int coord_w = $clog2(((img_w > img_h) ? img_w : img_h) + 1);

  // cascade shape
  localparam int num_features      = 4;
  localparam int num_stages        = 2;
  localparam int rects_per_feature = 2;

  localparam int feat_w  = $clog2(num_features);
  localparam int rect_w  = $clog2(rects_per_feature);
  localparam int stage_w = $clog2(num_stages);

  // stage s covers features stage_first_feature[s] .. stage_first_feature[s+1]-1
  localparam logic [feat_w:0] stage_first_feature [num_stages+1] = '{0, 2, 4};

  localparam logic signed [acc_w-1:0] stage_threshold [num_stages] = '{0, 1};

  // rectangles inside the window, indexed [feature][rectangle]
  // f0 wide top/bottom edge, f1 narrow center edge, f2 single row edge, f3 left/right balance
  localparam logic [coord_w-1:0] rect_x [num_features][rects_per_feature] = '{
    '{0, 0}, '{1, 1}, '{0, 0}, '{0, 3}
  };
  localparam logic [coord_w-1:0] rect_y [num_features][rects_per_feature] = '{
    '{0, 3}, '{1, 3}, '{2, 3}, '{0, 0}
  };
  localparam logic [coord_w-1:0] rect_w_tab [num_features][rects_per_feature] = '{
    '{6, 6}, '{4, 4}, '{6, 6}, '{3, 3}
  };
  localparam logic [coord_w-1:0] rect_h [num_features][rects_per_feature] = '{
    '{3, 3}, '{2, 2}, '{1, 1}, '{6, 6}
  };

  localparam logic signed [acc_w-1:0] rect_weight [num_features][rects_per_feature] = '{
    '{-1, 1}, '{-1, 1}, '{-1, 1}, '{1, -1}
  };

  localparam logic signed [acc_w-1:0] feature_threshold [num_features] = '{
    900, 400, 500, -300
  };
  localparam logic signed [acc_w-1:0] feature_above [num_features] = '{2, 1, 1, 1};
  localparam logic signed [acc_w-1:0] feature_below [num_features] = '{-1, -1, -1, -1};

  typedef enum logic [2:0] {
    idle,
    eval,   // one rectangle per cycle
    vote,   // last vote of the stage lands
    check,  // stage close and result
    done
  } scan_state_t;

endpackage

`default_nettype wire

// File: src/integral_image.sv
// streaming integral image
`timescale 1ns/1ps
`default_nettype none

module integral_image #(
  parameter int img_w = vj_pkg::img_w,
  parameter int img_h = vj_pkg::img_h
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [vj_pkg::pixel_w-1:0] pixel,
  input  logic                       pixel_valid,
  input  logic                       load_enable,
  input  logic [vj_pkg::coord_w-1:0] corner_row [4],
  input  logic [vj_pkg::coord_w-1:0] corner_col [4],
  output logic [vj_pkg::sum_w-1:0]   corner_value [4],
  output logic                       frame_loaded
);
  import vj_pkg::*;

  // padded by one row and one column of zeros
  logic [sum_w-1:0]   ii_mem [img_h+1][img_w+1];

  logic [coord_w-1:0] col_count;   // raster position of the next accepted pixel
  logic [coord_w-1:0] row_count;
  logic               frame_full;  // frame complete, wait for the scan
  logic               accept;
  logic               last_pos;

  logic               wr_en;
  logic [coord_w-1:0] wr_col;
  logic [coord_w-1:0] wr_row;
  logic [pixel_w-1:0] wr_pixel;
  logic [sum_w-1:0]   row_sum;
  logic [sum_w-1:0]   row_sum_next;

  assign accept   = pixel_valid && load_enable && !frame_full;
  assign last_pos = (col_count == coord_w'(img_w - 1)) && (row_count == coord_w'(img_h - 1));

  assign row_sum_next = ((wr_col == '0) ? '0 : row_sum) + sum_w'(wr_pixel);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      col_count    <= '0;
      row_count    <= '0;
      frame_full   <= 1'b0;
      wr_en        <= 1'b0;
      frame_loaded <= 1'b0;
    end else begin
      wr_en        <= accept;
      frame_loaded <= wr_en && (wr_col == coord_w'(img_w - 1)) &&
                      (wr_row == coord_w'(img_h - 1));
      if (!load_enable) begin
        frame_full <= 1'b0;  // scan running, next frame may follow
      end else if (accept && last_pos) begin
        frame_full <= 1'b1;
      end
      if (accept) begin
        if (col_count == coord_w'(img_w - 1)) begin
          col_count <= '0;
          row_count <= last_pos ? '0 : row_count + 1'b1;
        end else begin
          col_count <= col_count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      wr_pixel <= pixel;
      wr_col   <= col_count;
      wr_row   <= row_count;
    end
    if (wr_en) row_sum <= row_sum_next;
  end

  always_ff @(posedge clock) begin
    for (int c = 0; c <= img_w; c++) ii_mem[0][c] <= '0;
    for (int r = 1; r <= img_h; r++) ii_mem[r][0] <= '0;
    if (wr_en) begin
      ii_mem[wr_row + 1'b1][wr_col + 1'b1] <= row_sum_next + ii_mem[wr_row][wr_col + 1'b1];
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) corner_value[i] = ii_mem[corner_row[i]][corner_col[i]];
  end

  for (genvar i = 0; i < 4; i++) begin : g_addr_check
    a_corner_in_range: assert property (@(posedge clock) disable iff (reset)
      (corner_row[i] <= img_h) && (corner_col[i] <= img_w))
      else $error("corner %0d address outside the integral image", i);
  end

endmodule

`default_nettype wire

// File: src/scan_control.sv
// window scan and cascade sequencer
`timescale 1ns/1ps
`default_nettype none

module scan_control #(
  parameter int img_w    = vj_pkg::img_w,
  parameter int img_h    = vj_pkg::img_h,
  parameter int win_size = vj_pkg::win_size
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       frame_loaded,
  input  logic                       stage_pass,
  input  logic                       stage_result_valid,
  output logic                       load_enable,
  output logic                       busy,
  output logic [vj_pkg::coord_w-1:0] win_row,
  output logic [vj_pkg::coord_w-1:0] win_col,
  output logic [vj_pkg::feat_w-1:0]  feature_index,
  output logic [vj_pkg::rect_w-1:0]  rect_index,
  output logic                       rect_last,
  output logic                       eval_step,
  output logic [vj_pkg::stage_w-1:0] stage_index,
  output logic                       stage_close,
  output logic                       window_start,
  output logic                       face_valid,
  output logic [vj_pkg::coord_w-1:0] face_row,
  output logic [vj_pkg::coord_w-1:0] face_col,
  output logic                       scan_done
);
  import vj_pkg::*;

  localparam logic [coord_w-1:0] last_col = coord_w'(img_w - win_size);
  localparam logic [coord_w-1:0] last_row = coord_w'(img_h - win_size);

  scan_state_t     state;
  logic [feat_w:0] feature_next;
  logic            last_in_stage;
  logic            last_stage;
  logic            last_window;

  assign feature_next  = {1'b0, feature_index} + 1'b1;
  assign last_in_stage = feature_next == stage_first_feature[int'(stage_index) + 1];
  assign last_stage    = stage_index == stage_w'(num_stages - 1);
  assign last_window   = (win_row == last_row) && (win_col == last_col);

  assign rect_last   = rect_index == rect_w'(rects_per_feature - 1);
  assign eval_step   = state == eval;
  assign busy        = (state == eval) || (state == vote) || (state == check);
  assign load_enable = !busy;
  assign scan_done   = state == done;

  // window survived the last stage
  assign face_valid = (state == check) && stage_result_valid && stage_pass && last_stage;
  assign face_row   = win_row;
  assign face_col   = win_col;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state         <= idle;
      win_row       <= '0;
      win_col       <= '0;
      feature_index <= '0;
      rect_index    <= '0;
      stage_index   <= '0;
      stage_close   <= 1'b0;
      window_start  <= 1'b0;
    end else begin
      stage_close  <= 1'b0;
      window_start <= 1'b0;
      case (state)
        idle: begin
          if (frame_loaded) begin
            state         <= eval;
            win_row       <= '0;
            win_col       <= '0;
            feature_index <= '0;
            rect_index    <= '0;
            stage_index   <= '0;
            window_start  <= 1'b1;
          end
        end
        eval: begin
          if (rect_last) begin
            rect_index <= '0;
            if (last_in_stage) state <= vote;
            else feature_index <= feature_index + 1'b1;  // vote of this feature lands next cycle
          end else begin
            rect_index <= rect_index + 1'b1;
          end
        end
        vote: begin
          stage_close <= 1'b1;
          state       <= check;
        end
        check: begin
          if (stage_result_valid) begin
            if (stage_pass && !last_stage) begin
              stage_index   <= stage_index + 1'b1;
              feature_index <= feature_index + 1'b1;
              state         <= eval;
            end else if (last_window) begin
              state <= done;
            end else begin
              // rejected or reported, move to the next origin
              state         <= eval;
              window_start  <= 1'b1;
              feature_index <= '0;
              stage_index   <= '0;
              if (win_col == last_col) begin
                win_col <= '0;
                win_row <= win_row + 1'b1;
              end else begin
                win_col <= win_col + 1'b1;
              end
            end
          end
        end
        done:    state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // a loaded frame must find the sequencer waiting
  a_frame_while_idle: assert property (@(posedge clock) disable iff (reset)
    frame_loaded |-> state == idle)
    else $error("frame loaded while a scan is running");

endmodule

`default_nettype wire

// File: src/feature_eval.sv
// haar feature datapath
`timescale 1ns/1ps
`default_nettype none

module feature_eval #(
  parameter int win_size = vj_pkg::win_size
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [vj_pkg::coord_w-1:0]     win_row,
  input  logic [vj_pkg::coord_w-1:0]     win_col,
  input  logic [vj_pkg::feat_w-1:0]      feature_index,
  input  logic [vj_pkg::rect_w-1:0]      rect_index,
  input  logic                           rect_last,
  input  logic                           eval_step,
  output logic [vj_pkg::coord_w-1:0]     corner_row [4],
  output logic [vj_pkg::coord_w-1:0]     corner_col [4],
  input  logic [vj_pkg::sum_w-1:0]       corner_value [4],
  output logic signed [vj_pkg::acc_w-1:0] vote,
  output logic                           vote_valid
);
  import vj_pkg::*;

  logic [coord_w-1:0]      x_off;
  logic [coord_w-1:0]      y_off;
  logic [coord_w-1:0]      w_off;
  logic [coord_w-1:0]      h_off;
  logic [coord_w-1:0]      top;
  logic [coord_w-1:0]      bottom;
  logic [coord_w-1:0]      left;
  logic [coord_w-1:0]      right;
  logic [sum_w-1:0]        rect_sum;
  logic signed [acc_w-1:0] rect_sum_ext;
  logic signed [acc_w-1:0] weighted;
  logic signed [acc_w-1:0] feature_sum;
  logic signed [acc_w-1:0] sum_next;

  assign x_off = rect_x[feature_index][rect_index];
  assign y_off = rect_y[feature_index][rect_index];
  assign w_off = rect_w_tab[feature_index][rect_index];
  assign h_off = rect_h[feature_index][rect_index];

  assign top    = win_row + y_off;
  assign bottom = top + h_off;
  assign left   = win_col + x_off;
  assign right  = left + w_off;

  // 0 top-left, 1 top-right, 2 bottom-left, 3 bottom-right
  assign corner_row[0] = top;
  assign corner_col[0] = left;
  assign corner_row[1] = top;
  assign corner_col[1] = right;
  assign corner_row[2] = bottom;
  assign corner_col[2] = left;
  assign corner_row[3] = bottom;
  assign corner_col[3] = right;

  assign rect_sum     = corner_value[3] - corner_value[2] - corner_value[1] + corner_value[0];
  assign rect_sum_ext = acc_w'(rect_sum);
  assign weighted     = rect_sum_ext * rect_weight[feature_index][rect_index];
  assign sum_next     = ((rect_index == '0) ? '0 : feature_sum) + weighted;  // restart per feature

  always_ff @(posedge clock or posedge reset) begin
    if (reset) vote_valid <= 1'b0;
    else       vote_valid <= eval_step && rect_last;
  end

  always_ff @(posedge clock) begin
    if (eval_step) begin
      feature_sum <= sum_next;
      if (rect_last) begin
        vote <= (sum_next > feature_threshold[feature_index]) ?
                feature_above[feature_index] : feature_below[feature_index];
      end
    end
  end

  a_rect_in_window: assert property (@(posedge clock) disable iff (reset)
    eval_step |-> (y_off + h_off <= win_size) && (x_off + w_off <= win_size))
    else $error("feature %0d rectangle %0d leaves the window", feature_index, rect_index);

endmodule

`default_nettype wire

// File: src/stage_accum.sv
// cascade stage vote accumulator
`timescale 1ns/1ps
`default_nettype none

module stage_accum (
  input  logic                            clock,
  input  logic                            reset,
  input  logic signed [vj_pkg::acc_w-1:0] vote,
  input  logic                            vote_valid,
  input  logic [vj_pkg::stage_w-1:0]      stage_index,
  input  logic                            stage_close,
  input  logic                            window_start,
  output logic                            stage_pass,
  output logic                            stage_result_valid
);
  import vj_pkg::*;

  logic signed [acc_w-1:0] stage_sum;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      stage_sum          <= '0;
      stage_pass         <= 1'b0;
      stage_result_valid <= 1'b0;
    end else begin
      stage_result_valid <= stage_close;
      if (stage_close) begin
        stage_pass <= stage_sum > stage_threshold[stage_index];
        stage_sum  <= '0;  // next stage starts fresh
      end else if (window_start) begin
        stage_sum <= '0;
      end else if (vote_valid) begin
        stage_sum <= stage_sum + vote;
      end
    end
  end

  // the last vote of a stage must be in the sum before it is closed
  a_close_after_vote: assert property (@(posedge clock) disable iff (reset)
    !(stage_close && vote_valid))
    else $error("stage %0d closed while a vote was arriving", stage_index);

endmodule

`default_nettype wire

// File: src/face_detect_top.sv
// viola-jones face detector top
`timescale 1ns/1ps
`default_nettype none

module face_detect_top #(
  parameter int img_w    = vj_pkg::img_w,
  parameter int img_h    = vj_pkg::img_h,
  parameter int win_size = vj_pkg::win_size
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [vj_pkg::pixel_w-1:0] pixel,
  input  logic                       pixel_valid,
  output logic                       busy,
  output logic                       face_valid,
  output logic [vj_pkg::coord_w-1:0] face_row,
  output logic [vj_pkg::coord_w-1:0] face_col,
  output logic                       scan_done
);
  import vj_pkg::*;

  logic                    frame_loaded;
  logic                    load_enable;
  logic [coord_w-1:0]      corner_row [4];
  logic [coord_w-1:0]      corner_col [4];
  logic [sum_w-1:0]        corner_value [4];
  logic [coord_w-1:0]      win_row;
  logic [coord_w-1:0]      win_col;
  logic [feat_w-1:0]       feature_index;
  logic [rect_w-1:0]       rect_index;
  logic                    rect_last;
  logic                    eval_step;
  logic [stage_w-1:0]      stage_index;
  logic                    stage_close;
  logic                    window_start;
  logic signed [acc_w-1:0] vote;
  logic                    vote_valid;
  logic                    stage_pass;
  logic                    stage_result_valid;

  integral_image #(.img_w(img_w), .img_h(img_h)) u_integral_image (
    .clock, .reset,
    .pixel, .pixel_valid, .load_enable,
    .corner_row, .corner_col, .corner_value,
    .frame_loaded
  );

  scan_control #(.img_w(img_w), .img_h(img_h), .win_size(win_size)) u_scan_control (
    .clock, .reset,
    .frame_loaded, .stage_pass, .stage_result_valid,
    .load_enable, .busy,
    .win_row, .win_col, .feature_index, .rect_index, .rect_last, .eval_step,
    .stage_index, .stage_close, .window_start,
    .face_valid, .face_row, .face_col, .scan_done
  );

  feature_eval #(.win_size(win_size)) u_feature_eval (
    .clock, .reset,
    .win_row, .win_col, .feature_index, .rect_index, .rect_last, .eval_step,
    .corner_row, .corner_col, .corner_value,
    .vote, .vote_valid
  );

  stage_accum u_stage_accum (
    .clock, .reset,
    .vote, .vote_valid,
    .stage_index, .stage_close, .window_start,
    .stage_pass, .stage_result_valid
  );

endmodule

`default_nettype wire

// File: sim/face_model.svh
// face detector reference model
`ifndef FACE_MODEL_SVH
`define FACE_MODEL_SVH

int               frame_pix [img_h][img_w];      // frame under test
int               ii_ref [img_h+1][img_w+1];     // padded integral image
logic [coord_w-1:0] exp_row [$];                 // expected face origins, raster order
logic [coord_w-1:0] exp_col [$];

// row 0 and column 0 stay zero
function automatic void build_integral();
  for (int r = 0; r <= img_h; r++) begin
    for (int c = 0; c <= img_w; c++) begin
      if (r == 0 || c == 0) ii_ref[r][c] = 0;
      else ii_ref[r][c] = frame_pix[r-1][c-1] + ii_ref[r-1][c] + ii_ref[r][c-1]
                          - ii_ref[r-1][c-1];
    end
  end
endfunction

// pixel sum of a rectangle from its four corners
function automatic int box_sum(int top, int left, int height, int width);
  return ii_ref[top+height][left+width] - ii_ref[top][left+width]
         - ii_ref[top+height][left] + ii_ref[top][left];
endfunction

function automatic int feature_vote(int f, int row, int col);
  int total;
  total = 0;
  for (int r = 0; r < rects_per_feature; r++) begin
    total += int'(rect_weight[f][r]) *
             box_sum(row + int'(rect_y[f][r]), col + int'(rect_x[f][r]),
                     int'(rect_h[f][r]), int'(rect_w_tab[f][r]));
  end
  return (total > int'(feature_threshold[f])) ? int'(feature_above[f]) : int'(feature_below[f]);
endfunction

function automatic bit window_passes(int row, int col);
  int stage_sum;
  for (int s = 0; s < num_stages; s++) begin
    stage_sum = 0;
    for (int f = int'(stage_first_feature[s]); f < int'(stage_first_feature[s+1]); f++) begin
      stage_sum += feature_vote(f, row, col);
    end
    if (!(stage_sum > int'(stage_threshold[s]))) return 1'b0;  // rejected here
  end
  return 1'b1;
endfunction

// queues the expected origins and returns how many
function automatic int predict_faces();
  int count;
  count = 0;
  build_integral();
  for (int row = 0; row <= img_h - win_size; row++) begin
    for (int col = 0; col <= img_w - win_size; col++) begin
      if (window_passes(row, col)) begin
        exp_row.push_back(coord_w'(row));
        exp_col.push_back(coord_w'(col));
        count++;
      end
    end
  end
  return count;
endfunction

`endif

// File: sim/face_detect_tb.sv
// face detector testbench
`timescale 1ns/1ps
`default_nettype none

module face_detect_tb;
  import vj_pkg::*;

  localparam int frames  = 4;
  localparam int windows = (img_w - win_size + 1) * (img_h - win_size + 1);
  localparam int timeout_cycles = frames * (img_w * img_h * 4 + windows * 16) + 1000;

  logic               clock = 1'b0;
  logic               reset;
  logic [pixel_w-1:0] pixel;
  logic               pixel_valid;
  logic               busy;
  logic               face_valid;
  logic [coord_w-1:0] face_row;
  logic [coord_w-1:0] face_col;
  logic               scan_done;

  logic   frame_sent;  // last pixel of the first frame driven
  int     done_count;
  int     faces;
  integer seed = 32'hd37d_b9d4;

  `include "face_model.svh"

  face_detect_top UUT (
    .clock, .reset, .pixel, .pixel_valid,
    .busy, .face_valid, .face_row, .face_col, .scan_done
  );

  always #5 clock = ~clock;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // rows above split get the dark value
  function automatic void fill_band(int split, int dark, int bright);
    for (int r = 0; r < img_h; r++)
      for (int c = 0; c < img_w; c++) frame_pix[r][c] = (r < split) ? dark : bright;
  endfunction

  function automatic void fill_random();
    for (int r = 0; r < img_h; r++)
      for (int c = 0; c < img_w; c++) frame_pix[r][c] = $random(seed) & 255;
  endfunction

  task automatic send_frame(input bit gaps);
    int gap;
    for (int i = 0; i < img_w * img_h; i++) begin
      gap = gaps ? ($random(seed) & 3) : 0;
      repeat (gap) begin
        @(posedge clock);
        pixel_valid <= 1'b0;
      end
      @(posedge clock);
      pixel       <= pixel_w'(frame_pix[i / img_w][i % img_w]);
      pixel_valid <= 1'b1;
    end
    @(posedge clock);
    pixel_valid <= 1'b0;
    frame_sent  <= 1'b1;
  endtask

  // junk during the scan, must be ignored
  task automatic inject_while_busy();
    do @(negedge clock); while (!busy);
    repeat (30) begin
      @(posedge clock);
      pixel       <= pixel_w'($random(seed));
      pixel_valid <= 1'b1;
    end
    @(posedge clock);
    pixel_valid <= 1'b0;
  endtask

  task automatic run_frame(input bit gaps, input bit inject, output int predicted);
    int done_before;
    predicted   = predict_faces();
    done_before = done_count;
    send_frame(gaps);
    if (inject) inject_while_busy();
    do @(negedge clock); while (!scan_done);
    @(negedge clock);
    assert (done_count == done_before + 1)
      else report_failure("scan_done did not pulse exactly once for the frame");
  endtask

  // face reports against the model, in order
  always @(negedge clock) begin
    if (!reset && face_valid) begin
      assert (exp_row.size() > 0)
        else report_failure("face reported where the model expects none");
      assert (face_row == exp_row[0])
        else report_failure($sformatf("ERROR face_row got 0x%h expected 0x%h",
                                      face_row, exp_row[0]));
      assert (face_col == exp_col[0])
        else report_failure($sformatf("ERROR face_col got 0x%h expected 0x%h",
                                      face_col, exp_col[0]));
      void'(exp_row.pop_front());
      void'(exp_col.pop_front());
    end
    if (!reset && scan_done) begin
      done_count++;
      assert (exp_row.size() == 0)
        else report_failure($sformatf("scan ended with %0d expected faces missing",
                                      exp_row.size()));
    end
  end

  a_quiet_before_frame: assert property (@(posedge clock) disable iff (reset)
    !frame_sent |-> !busy && !face_valid && !scan_done)
    else report_failure("DUT became active before the first frame was sent");

  a_face_inside_scan: assert property (@(posedge clock) disable iff (reset)
    face_valid |-> busy)
    else report_failure("face_valid seen outside a scan");

  a_done_ends_busy: assert property (@(posedge clock) disable iff (reset)
    scan_done |-> !busy && $past(busy))
    else report_failure("scan_done did not coincide with busy falling");

  a_done_single: assert property (@(posedge clock) disable iff (reset)
    scan_done |=> !scan_done)
    else report_failure("scan_done held for more than one cycle");

  initial begin
    reset       = 1'b1;
    pixel       = '0;
    pixel_valid = 1'b0;
    frame_sent  = 1'b0;
    done_count  = 0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    fill_band(img_h / 2, 128, 128);  // uniform mid-gray
    run_frame(1'b0, 1'b0, faces);
    assert (faces == 0) else report_failure("model expects faces in the gray frame");

    fill_band(img_h / 2, 20, 200);
    run_frame(1'b0, 1'b0, faces);
    assert (faces > 0) else report_failure("band frame gives no faces to compare");

    fill_random();
    run_frame(1'b1, 1'b1, faces);

    fill_band(7, 40, 180);  // next frame after the junk pixels
    run_frame(1'b1, 1'b0, faces);

    repeat (20) @(negedge clock);
    assert (done_count == frames && !busy)
      else report_failure("scan activity after the last frame");
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    report_failure("timeout, the frames did not finish in time");
  end

endmodule

`default_nettype wire

// File: face_detect_top.f
+incdir+sim
src/vj_pkg.sv
src/integral_image.sv
src/scan_control.sv
src/feature_eval.sv
src/stage_accum.sv
src/face_detect_top.sv
sim/face_detect_tb.sv

// File: Bender.yml
package:
  name: face_detect

sources:
  - src/vj_pkg.sv
  - src/integral_image.sv
  - src/scan_control.sv
  - src/feature_eval.sv
  - src/stage_accum.sv
  - src/face_detect_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/face_detect_tb.sv
